// File: Bender.yml
package:
  name: jpeg_capture

sources:
  - files:
      - hdl/jpeg_capture_pkg.sv
      - hdl/jpeg_qword_packer.sv
      - hdl/jpeg_buffer_cdc.sv
      - hdl/jpeg_frame_buffer.sv
      - hdl/jpeg_capture_regs.sv
      - hdl/jpeg_capture_top.sv
  - target: simulation
    files:
      - sim/jpeg_capture_tb.sv

// File: hdl/jpeg_buffer_cdc.sv
module jpeg_buffer_cdc
    import jpeg_capture_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic        clock_spi_in,
    input  logic        arst_n,
    input  logic        restart,
    input  jpeg_qword_t qword,
    input  logic        qword_valid,
    output buf_write_t  buf_wr,
    output frame_info_t frame
);

    localparam int QWORD_CNT_W = ADDR_WIDTH - 2;

    logic [127:0]           data_rev;
    logic [2:0]             valid_sync;
    logic                   valid_edge;
    logic                   start;
    logic [1:0]             word_cnt;
    logic [QWORD_CNT_W-1:0] qword_cnt;
    logic [95:0]            cap_data;
    logic [4:0]             cap_bytes;
    logic                   cap_last;

    // first byte of the stream goes to byte 0 of word 0
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            data_rev[8*i +: 8] = qword.data[8*(15-i) +: 8];
        end
    end

    assign valid_edge = valid_sync[2:1] == 2'b01;
    assign start      = valid_edge && word_cnt == 2'd0;

    always_ff @(posedge clock_spi_in or negedge arst_n) begin
        if (!arst_n) begin
            valid_sync <= '0;
            word_cnt   <= '0;
            qword_cnt  <= '0;
        end else begin
            valid_sync[1:0] <= {valid_sync[0], qword_valid};
            // keep the edge pending while word 3 is still being written
            if (!(valid_edge && word_cnt == 2'd3)) begin
                valid_sync[2] <= valid_sync[1];
            end
            if (restart) begin
                word_cnt  <= '0;
                qword_cnt <= '0;
            end else begin
                if (valid_edge || word_cnt != 2'd0) begin
                    word_cnt <= word_cnt + 2'd1;
                end
                if (word_cnt == 2'd3) begin
                    qword_cnt <= cap_last ? '0 : qword_cnt + 1'b1;
                end
            end
        end
    end

    // qword is held by the packer long after the edge, so one capture is enough
    always_ff @(posedge clock_spi_in) begin
        if (start) begin
            cap_data  <= data_rev[127:32];
            cap_bytes <= qword.bytes;
            cap_last  <= qword.last;
        end
    end

    always_comb begin
        buf_wr.addr = BUF_ADDR_MAX_W'({qword_cnt, word_cnt});
        if (word_cnt == 2'd0) begin
            buf_wr.data = data_rev[31:0];
            buf_wr.en   = start;
        end else begin
            buf_wr.data = cap_data[32*(int'(word_cnt) - 1) +: 32];
            buf_wr.en   = cap_bytes > {1'b0, word_cnt, 2'b00};
        end
        // earlier quad-words of the frame are always full
        frame.done       = word_cnt == 2'd3 && cap_last;
        frame.byte_count = 20'({qword_cnt, 4'b0000}) + 20'(cap_bytes);
    end

endmodule

// File: hdl/jpeg_capture_pkg.sv
package jpeg_capture_pkg;

    // widest buffer word address carried on the write bus
    localparam int BUF_ADDR_MAX_W = 14;

    // host register map
    localparam logic [31:0] REG_CTRL   = 32'h0000_0000;
    localparam logic [31:0] REG_STATUS = 32'h0000_0004;
    localparam logic [31:0] REG_BYTES  = 32'h0000_0008;
    localparam logic [31:0] BUF_BASE   = 32'h0001_0000;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } jpeg_byte_t;

    // first byte of the quad-word sits in data[127:120]
    typedef struct packed {
        logic [127:0] data;
        logic [4:0]   bytes;
        logic         last;
    } jpeg_qword_t;

    typedef struct packed {
        logic [BUF_ADDR_MAX_W-1:0] addr;
        logic [31:0]               data;
        logic                      en;
    } buf_write_t;

    typedef struct packed {
        logic        done;
        logic [19:0] byte_count;
    } frame_info_t;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: hdl/jpeg_capture_regs.sv
module jpeg_capture_regs
    import jpeg_capture_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clock_spi_in,
    input  logic                  arst_n,
    input  axil_req_t             axil_req,
    output axil_rsp_t             axil_rsp,
    input  frame_info_t           frame,
    output logic                  restart,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic [31:0]           rd_data
);

    logic        wr_accept;
    logic        rd_accept;
    logic        ctrl_hit;
    logic [31:0] buf_off;
    logic        in_window;
    logic        reg_hit;
    logic [31:0] reg_rdata;
    logic        bvalid;
    logic        rvalid;
    logic        rd_pending;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    logic        done_flag;
    logic [19:0] byte_count;

    // address and data are taken together, and only with no response held
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_accept = axil_req.arvalid && !rvalid && !rd_pending;
    assign ctrl_hit  = axil_req.awaddr == REG_CTRL;

    // buffer window decode
    assign buf_off   = axil_req.araddr - BUF_BASE;
    assign in_window = axil_req.araddr >= BUF_BASE && buf_off < (32'd1 << (ADDR_WIDTH + 2));
    assign rd_addr   = buf_off[ADDR_WIDTH+1:2];

    always_comb begin
        reg_hit = 1'b1;
        case (axil_req.araddr)
            REG_CTRL:   reg_rdata = '0;
            REG_STATUS: reg_rdata = {31'd0, done_flag};
            REG_BYTES:  reg_rdata = {12'd0, byte_count};
            default: begin
                reg_hit   = 1'b0;
                reg_rdata = '0;
            end
        endcase
    end

    always_ff @(posedge clock_spi_in or negedge arst_n) begin
        if (!arst_n) begin
            restart    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            rd_pending <= 1'b0;
            done_flag  <= 1'b0;
            byte_count <= '0;
        end else begin
            restart <= wr_accept && ctrl_hit && axil_req.wstrb[0] && axil_req.wdata[0];
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            // buffer reads wait one extra cycle for the memory
            rd_pending <= rd_accept && in_window;
            if ((rd_accept && !in_window) || rd_pending) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
            if (restart) begin
                done_flag  <= 1'b0;
                byte_count <= '0;
            end else if (frame.done) begin
                done_flag  <= 1'b1;
                byte_count <= frame.byte_count;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (wr_accept) begin
            bresp <= ctrl_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept && !in_window) begin
            rdata <= reg_rdata;
            rresp <= reg_hit ? RESP_OKAY : RESP_SLVERR;
        end else if (rd_pending) begin
            rdata <= rd_data;
            rresp <= RESP_OKAY;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = rd_accept;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

endmodule

// File: hdl/jpeg_capture_top.sv
module jpeg_capture_top
    import jpeg_capture_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic       clock_pixel_in,
    input  logic       clock_spi_in,
    input  logic       arst_n,
    input  jpeg_byte_t enc_byte,
    input  logic       enc_valid,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp
);

    // pixel domain
    jpeg_qword_t           qword;
    logic                  qword_valid;

    // fast domain
    buf_write_t            buf_wr;
    frame_info_t           frame;
    logic                  restart;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [31:0]           rd_data;

    jpeg_qword_packer packer_i (
        .clock_pixel_in (clock_pixel_in),
        .arst_n         (arst_n),
        .in_byte        (enc_byte),
        .in_valid       (enc_valid),
        .qword          (qword),
        .qword_valid    (qword_valid)
    );

    jpeg_buffer_cdc #(.ADDR_WIDTH(ADDR_WIDTH)) cdc_i (
        .clock_spi_in (clock_spi_in),
        .arst_n       (arst_n),
        .restart      (restart),
        .qword        (qword),
        .qword_valid  (qword_valid),
        .buf_wr       (buf_wr),
        .frame        (frame)
    );

    jpeg_frame_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) buffer_i (
        .clock_spi_in (clock_spi_in),
        .wr           (buf_wr),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    jpeg_capture_regs #(.ADDR_WIDTH(ADDR_WIDTH)) regs_i (
        .clock_spi_in (clock_spi_in),
        .arst_n       (arst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .frame        (frame),
        .restart      (restart),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

// File: hdl/jpeg_frame_buffer.sv
module jpeg_frame_buffer
    import jpeg_capture_pkg::*;
#(
    parameter int ADDR_WIDTH = 14
) (
    input  logic                  clock_spi_in,
    input  buf_write_t            wr,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [31:0]           rd_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // one word per four stream bytes
    logic [31:0] mem [DEPTH];

    always_ff @(posedge clock_spi_in) begin
        if (wr.en) begin
            mem[wr.addr[ADDR_WIDTH-1:0]] <= wr.data;
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge clock_spi_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/jpeg_qword_packer.sv
module jpeg_qword_packer
    import jpeg_capture_pkg::*;
(
    input  logic        clock_pixel_in,
    input  logic        arst_n,
    input  jpeg_byte_t  in_byte,
    input  logic        in_valid,
    output jpeg_qword_t qword,
    output logic        qword_valid
);

    logic [127:0] acc;
    logic [127:0] acc_next;
    logic [4:0]   cnt;
    logic [4:0]   cnt_next;
    logic [4:0]   pad_bytes;
    logic         emit;

    // newest byte enters at the bottom, oldest drifts towards the top
    assign acc_next = {acc[119:0], in_byte.data};
    assign cnt_next = cnt + 5'd1;

    // a full quad-word or the end of the frame closes the group
    assign emit = in_valid && (cnt_next == 5'd16 || in_byte.last);

    // unused byte slots below a short group
    assign pad_bytes = 5'd16 - cnt_next;

    always_ff @(posedge clock_pixel_in or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            qword_valid <= 1'b0;
        end else begin
            qword_valid <= emit;
            if (in_valid) begin
                if (emit) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt_next;
                end
            end
        end
    end

    // stale bytes above a short group are shifted out by the left alignment
    always_ff @(posedge clock_pixel_in) begin
        if (in_valid) begin
            acc <= acc_next;
        end
        if (emit) begin
            qword.data  <= acc_next << {pad_bytes, 3'b000};
            qword.bytes <= cnt_next;
            qword.last  <= in_byte.last;
        end
    end

endmodule

// File: project.f
hdl/jpeg_capture_pkg.sv
hdl/jpeg_qword_packer.sv
hdl/jpeg_buffer_cdc.sv
hdl/jpeg_frame_buffer.sv
hdl/jpeg_capture_regs.sv
hdl/jpeg_capture_top.sv
sim/jpeg_capture_tb.sv

// File: sim/jpeg_capture_tb.sv
module jpeg_capture_tb
    import jpeg_capture_pkg::*;
();

    localparam int ADDR_WIDTH = 14;

    // kinds of queued checks
    localparam logic [1:0] K_WORD   = 2'd0;
    localparam logic [1:0] K_STATUS = 2'd1;
    localparam logic [1:0] K_RRESP  = 2'd2;
    localparam logic [1:0] K_BRESP  = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] got;
        logic [31:0] exp;
        logic [31:0] mask;
    } check_t;

    logic        clock_spi_in;
    logic        clock_pixel_in;
    logic        arst_n;
    jpeg_byte_t  enc_byte;
    logic        enc_valid;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    logic [15:0] lfsr;
    logic [7:0]  frame_bytes [256];
    logic [31:0] exp_words [64];
    check_t      check_q [$];
    event        check_ev;
    int          pending = 0;
    int          check_count = 0;
    int          err_count = 0;
    int          test_err_base = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          len_a;
    int          len_b;
    int          len_c;

    initial begin
        clock_spi_in = 1'b0;
        forever #20 clock_spi_in = ~clock_spi_in;
    end

    // pixel clock at half the rate of the fast clock
    initial begin
        clock_pixel_in = 1'b0;
        forever #40 clock_pixel_in = ~clock_pixel_in;
    end

    jpeg_capture_top #(.ADDR_WIDTH(ADDR_WIDTH)) dut_i (
        .clock_pixel_in (clock_pixel_in),
        .clock_spi_in   (clock_spi_in),
        .arst_n         (arst_n),
        .enc_byte       (enc_byte),
        .enc_valid      (enc_valid),
        .axil_req       (axil_req),
        .axil_rsp       (axil_rsp)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // 17 to 199 bytes, never a whole number of words
    function automatic int random_length();
        int len;
        len = 17 + int'(random_bits(8)) % 183;
        if (len % 4 == 0) begin
            len++;
        end
        return len;
    endfunction

    // byte k lands in word k/4, lane k mod 4
    function automatic int pack_words(input int len);
        for (int w = 0; w < 64; w++) begin
            exp_words[w] = '0;
        end
        for (int k = 0; k < len; k++) begin
            exp_words[k / 4][8 * (k % 4) +: 8] = frame_bytes[k];
        end
        return (len + 3) / 4;
    endfunction

    function automatic logic [31:0] lane_mask(input int len, input int w);
        int rem;
        rem = len - 4 * w;
        if (rem >= 4) begin
            return '1;
        end
        return (32'd1 << (8 * rem)) - 32'd1;
    endfunction

    task automatic queue_check(input logic [1:0] kind, input logic [31:0] addr,
            input logic [31:0] got, input logic [31:0] exp, input logic [31:0] mask);
        check_t c;
        c.kind = kind;
        c.addr = addr;
        c.got  = got;
        c.exp  = exp;
        c.mask = mask;
        check_q.push_back(c);
        pending++;
        -> check_ev;
    endtask

    task automatic compare_word(input logic [31:0] addr, input logic [31:0] got,
            input logic [31:0] exp, input logic [31:0] mask);
        check_count++;
        if ((got & mask) !== (exp & mask)) begin
            err_count++;
            $display("error: rdata at 0x%08h is 0x%08h, expected 0x%08h", addr, got, exp & mask);
        end
    endtask

    task automatic compare_status(input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: status done is 0x%0h, expected 0x%0h", got, exp);
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // compare process, drains the queue filled by the bus tasks
    initial begin
        check_t c;
        forever begin
            @(check_ev);
            while (check_q.size() > 0) begin
                c = check_q.pop_front();
                case (c.kind)
                    K_WORD:   compare_word(c.addr, c.got, c.exp, c.mask);
                    K_STATUS: compare_status(c.got[0], c.exp[0]);
                    K_RRESP:  compare_resp("rresp", c.got[1:0], c.exp[1:0]);
                    default:  compare_resp("bresp", c.got[1:0], c.exp[1:0]);
                endcase
                pending--;
            end
        end
    end

    // rvalid marks completion, rready stays high so it lasts one cycle
    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
            output logic [1:0] resp);
        @(negedge clock_spi_in);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        // address phase ends on the edge that sees arready
        do begin
            @(posedge clock_spi_in);
        end while (!axil_rsp.arready);
        @(negedge clock_spi_in);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) begin
            @(negedge clock_spi_in);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
            output logic [1:0] resp);
        @(negedge clock_spi_in);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        // address and data are handed over on the same edge
        do begin
            @(posedge clock_spi_in);
        end while (!(axil_rsp.awready && axil_rsp.wready));
        @(negedge clock_spi_in);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(negedge clock_spi_in);
        end
        resp = axil_rsp.bresp;
    endtask

    task automatic read_and_check(input logic [1:0] kind, input logic [31:0] addr,
            input logic [31:0] exp, input logic [31:0] mask, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        queue_check(kind, addr, data, exp, mask);
        queue_check(K_RRESP, addr, {30'd0, resp}, {30'd0, exp_resp}, '1);
    endtask

    task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
            input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        queue_check(K_BRESP, addr, {30'd0, resp}, {30'd0, exp_resp}, '1);
    endtask

    // encoder bytes on the pixel clock, no gaps
    task automatic send_frame(input int len);
        for (int k = 0; k < len; k++) begin
            frame_bytes[k] = random_bits(8);
        end
        for (int k = 0; k < len; k++) begin
            @(negedge clock_pixel_in);
            enc_byte.data = frame_bytes[k];
            enc_byte.last = (k == len - 1);
            enc_valid     = 1'b1;
        end
        @(negedge clock_pixel_in);
        enc_byte  = '0;
        enc_valid = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (!data[0]) begin
            axi_read(REG_STATUS, data, resp);
        end
    endtask

    task automatic check_frame(input int len);
        int n;
        n = pack_words(len);
        read_and_check(K_STATUS, REG_STATUS, 32'd1, 32'd1, RESP_OKAY);
        read_and_check(K_WORD, REG_BYTES, 32'(len), '1, RESP_OKAY);
        for (int w = 0; w < n; w++) begin
            read_and_check(K_WORD, BUF_BASE + 32'(4 * w), exp_words[w], lane_mask(len, w),
                RESP_OKAY);
        end
    endtask

    task automatic run_frame(input int len);
        send_frame(len);
        wait_done();
        check_frame(len);
    endtask

    task automatic finish_test(input string name);
        wait (pending == 0);
        $display("%s: %s, %0d errors", name, (err_count == test_err_base) ? "ok" : "failed",
            err_count - test_err_base);
        test_err_base = err_count;
    endtask

    always @(posedge clock_spi_in) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int reads;
        arst_n    = 1'b0;
        enc_byte  = '0;
        enc_valid = 1'b0;
        axil_req  = '0;
        lfsr      = 16'd10;
        len_a     = 64;
        len_b     = random_length();
        len_c     = random_length();
        // word reads, register reads, status polls and the final recheck
        reads = (len_a + 3) / 4 + (len_b + 3) / 4 + 2 * ((len_c + 3) / 4) + 60;
        cycle_limit = 2 * ((len_a + len_b + len_c) * 2 + reads * 6) + 500;
        repeat (8) @(negedge clock_spi_in);
        arst_n = 1'b1;

        read_and_check(K_STATUS, REG_STATUS, 32'd0, 32'd1, RESP_OKAY);
        read_and_check(K_WORD, REG_BYTES, 32'd0, '1, RESP_OKAY);
        finish_test("test 1, registers after reset");

        run_frame(len_a);
        finish_test("test 2, frame of 64 bytes");

        write_and_check(REG_CTRL, 32'd1, RESP_OKAY);
        run_frame(len_b);
        finish_test($sformatf("test 3, frame of %0d bytes", len_b));

        write_and_check(REG_CTRL, 32'd1, RESP_OKAY);
        read_and_check(K_STATUS, REG_STATUS, 32'd0, 32'd1, RESP_OKAY);
        read_and_check(K_WORD, REG_BYTES, 32'd0, '1, RESP_OKAY);
        run_frame(len_c);
        finish_test($sformatf("test 4, restart and frame of %0d bytes", len_c));

        // unmapped read, then a write to a read-only register
        read_and_check(K_WORD, 32'h0000_0020, 32'd0, '1, RESP_SLVERR);
        write_and_check(REG_STATUS, 32'd1, RESP_SLVERR);
        check_frame(len_c);
        finish_test("test 5, error responses");

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
